//--- logic/sdma_fifo_pkg.sv
// Shared types for the SCSI DMA data FIFO; the depth is fixed at eight words by the pointer and level widths
`default_nettype none

package sdma_fifo_pkg;

  typedef logic [31:0] word_t;     // Host long word
  typedef logic [7:0]  byte_t;     // SCSI byte
  typedef logic [2:0]  fifo_ptr_t; // Slot index, eight slots
  typedef logic [1:0]  byte_ofs_t; // 0 selects bits 31..24
  typedef logic [3:0]  level_t;    // Complete words held, 0..8
  typedef logic [3:0]  reg_addr_t; // Bus address bits 3..0

  localparam int FIFO_DEPTH = 8;

  // Register map
  localparam reg_addr_t REG_DATA   = 4'h0; // Write pushes, read pops
  localparam reg_addr_t REG_STATUS = 4'h4; // Read only
  localparam reg_addr_t REG_ACR    = 4'h8; // Write only, reads zero

  // ACR fields
  localparam int ACR_DIR    = 0; // 0 SCSI to host, 1 host to SCSI
  localparam int ACR_RST    = 1; // Strobe, never stored
  localparam int ACR_OFS_LO = 2; // Starting byte offset, 2 bits

  // STATUS fields
  localparam int STAT_EMPTY  = 0;
  localparam int STAT_FULL   = 1;
  localparam int STAT_LVL_LO = 2;  // 4 bits
  localparam int STAT_PTR_LO = 6;  // 2 bits
  localparam int STAT_OVF    = 8;
  localparam int STAT_UNF    = 9;
  localparam int STAT_DIR    = 10;

  typedef struct packed {
    logic      push;     // DATA write accepted in direction 1
    logic      pop;      // DATA read accepted in direction 0
    logic      acr_load; // ACR write accepted
    logic      dir;      // New direction
    logic      rst;      // FIFO reset strobe
    byte_ofs_t ofs;      // New byte offset
    word_t     wdata;
  } fifo_cmd_t;

  typedef struct packed {
    logic      empty;
    logic      full;
    level_t    level;
    byte_ofs_t byte_ofs;
    logic      overflow;
    logic      underflow;
    logic      dir;
    word_t     head;     // Word at the next-out slot
  } fifo_stat_t;

  typedef enum logic {
    DEC_IDLE,
    DEC_ACK
  } dec_state_t;

endpackage

`default_nettype wire

//--- logic/fifo_reg_decode.sv
// Bus decode for the FIFO; whole-word accesses only, wb_sel is not looked at and one wait state is fixed
`timescale 1ns/1ns
`default_nettype none

module fifo_reg_decode
  import sdma_fifo_pkg::*;
(
  input  wire        CLK,
  input  wire        arst_n,
  input  wire        wb_cyc,
  input  wire        wb_stb,
  input  wire        wb_we,
  input  reg_addr_t  wb_adr,
  input  word_t      wb_dat_w,
  output fifo_cmd_t  cmd,
  output logic       accept,
  output reg_addr_t  acc_adr
);

  dec_state_t state;
  logic       dir_q;   // Last loaded ACR direction
  logic       is_data; // Access hits the DATA register

  // A request is only taken while idle, the ack cycle ignores the bus
  assign accept  = (state == DEC_IDLE) && wb_cyc && wb_stb;
  assign acc_adr = wb_adr;
  assign is_data = (wb_adr == REG_DATA);

  always_comb begin
    cmd          = '0;
    cmd.push     = accept && wb_we && is_data && dir_q;   // Host to SCSI only
    cmd.pop      = accept && !wb_we && is_data && !dir_q; // SCSI to host only
    cmd.acr_load = accept && wb_we && (wb_adr == REG_ACR);
    cmd.dir      = wb_dat_w[ACR_DIR];
    cmd.rst      = wb_dat_w[ACR_RST];
    cmd.ofs      = wb_dat_w[ACR_OFS_LO +: 2];
    cmd.wdata    = wb_dat_w; // Push payload
  end

  // Ack cycle tracking
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state <= DEC_IDLE;
    end else begin
      case (state)
        DEC_IDLE: if (accept) state <= DEC_ACK;
        DEC_ACK:  state <= DEC_IDLE; // Exactly one cycle
        default:  state <= DEC_IDLE;
      endcase
    end
  end

  // Direction shadow so the buffer need not feed it back
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      dir_q <= 1'b0; // SCSI to host after reset
    end else if (cmd.acr_load) begin
      dir_q <= cmd.dir;
    end
  end

endmodule

`default_nettype wire

//--- logic/fifo_byte_lane_buffer.sv
// Eight-word byte-lane FIFO with one shared byte pointer; buffer lanes are not cleared, so unwritten lanes hold old data
`timescale 1ns/1ns
`default_nettype none

module fifo_byte_lane_buffer
  import sdma_fifo_pkg::*;
(
  input  wire        CLK,
  input  wire        arst_n,
  input  fifo_cmd_t  cmd,
  output fifo_stat_t stat,
  input  wire        byte_in_valid,
  input  byte_t      byte_in_data,
  output logic       byte_in_ready,
  output logic       byte_out_valid,
  output byte_t      byte_out_data,
  input  wire        byte_out_ready
);

  word_t     mem [FIFO_DEPTH]; // Long-word buffer, big-endian lanes
  fifo_ptr_t ni_ptr;           // Next in
  fifo_ptr_t no_ptr;           // Next out
  byte_ofs_t byte_ptr;
  level_t    level;
  logic      dir;
  logic      overflow;
  logic      underflow;

  logic      empty;
  logic      full;
  logic      in_fire;
  logic      out_fire;
  logic      push_ok;
  logic      pop_ok;
  logic      inc_ni;
  logic      inc_no;
  logic [3:0] lane_we;
  byte_t     lane_data [4];
  word_t     head;
  byte_ofs_t out_lane;

  assign empty = (level == level_t'(0));
  assign full  = (level == level_t'(FIFO_DEPTH));
  assign head  = mem[no_ptr];

  // Port handshakes
  assign byte_in_ready  = !dir && !full;
  assign byte_out_valid = dir && !empty;
  assign in_fire        = byte_in_valid && byte_in_ready;
  assign out_fire       = byte_out_valid && byte_out_ready;

  assign push_ok = cmd.push && !full;   // Push while full is dropped
  assign pop_ok  = cmd.pop && !empty;

  // Word boundaries move the slot pointers
  assign inc_ni = push_ok || (in_fire && (byte_ptr == 2'd3));
  assign inc_no = pop_ok || (out_fire && (byte_ptr == 2'd3));

  // Offset 0 lives in the top lane, so invert to get the lane index
  assign out_lane      = ~byte_ptr;
  assign byte_out_data = head[{out_lane, 3'b000} +: 8];

  // Lane strobes, a push fills all four, a SCSI byte fills one
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      lane_we[i]   = push_ok || (in_fire && (byte_ptr == byte_ofs_t'(i)));
      lane_data[i] = push_ok ? cmd.wdata[8*(3-i) +: 8] : byte_in_data;
    end
  end

  always_ff @(posedge CLK) begin
    for (int i = 0; i < 4; i++) begin
      if (lane_we[i]) mem[ni_ptr][8*(3-i) +: 8] <= lane_data[i];
    end
  end

  // Pointers, level and flags
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      ni_ptr    <= '0;
      no_ptr    <= '0;
      byte_ptr  <= '0;
      level     <= '0;
      dir       <= 1'b0;
      overflow  <= 1'b0;
      underflow <= 1'b0;
    end else if (cmd.acr_load && cmd.rst) begin
      ni_ptr    <= '0; // FIFO reset through the ACR
      no_ptr    <= '0;
      level     <= '0;
      overflow  <= 1'b0;
      underflow <= 1'b0;
      dir       <= cmd.dir;
      byte_ptr  <= cmd.ofs;
    end else begin
      if (inc_ni) ni_ptr <= ni_ptr + fifo_ptr_t'(1);
      if (inc_no) no_ptr <= no_ptr + fifo_ptr_t'(1);
      level <= level + level_t'(inc_ni) - level_t'(inc_no); // Both cancel
      if (cmd.push && full) overflow <= 1'b1;   // Sticky
      if (cmd.pop && empty) underflow <= 1'b1;  // Sticky
      if (cmd.acr_load) begin
        dir      <= cmd.dir;
        byte_ptr <= cmd.ofs; // Load wins over a byte move
      end else if (in_fire || out_fire) begin
        byte_ptr <= byte_ptr + byte_ofs_t'(1); // Wraps after offset 3
      end
    end
  end

  always_comb begin
    stat           = '0;
    stat.empty     = empty;
    stat.full      = full;
    stat.level     = level;
    stat.byte_ofs  = byte_ptr;
    stat.overflow  = overflow;
    stat.underflow = underflow;
    stat.dir       = dir;
    stat.head      = head;
  end

endmodule

`default_nettype wire

//--- logic/fifo_bus_response.sv
// Registered ack and read data; wb_dat_r is valid only in the ack cycle and holds its value otherwise
`timescale 1ns/1ns
`default_nettype none

module fifo_bus_response
  import sdma_fifo_pkg::*;
(
  input  wire        CLK,
  input  wire        arst_n,
  input  wire        accept,
  input  reg_addr_t  acc_adr,
  input  fifo_stat_t stat,
  output logic       wb_ack,
  output word_t      wb_dat_r
);

  word_t status_w;
  word_t rdata_nxt;

  // STATUS layout, unused bits read zero
  always_comb begin
    status_w                     = '0;
    status_w[STAT_EMPTY]         = stat.empty;
    status_w[STAT_FULL]          = stat.full;
    status_w[STAT_LVL_LO +: 4]   = stat.level;
    status_w[STAT_PTR_LO +: 2]   = stat.byte_ofs;
    status_w[STAT_OVF]           = stat.overflow;
    status_w[STAT_UNF]           = stat.underflow;
    status_w[STAT_DIR]           = stat.dir;
  end

  always_comb begin
    case (acc_adr)
      REG_STATUS: rdata_nxt = status_w;
      // Wrong direction or empty gives zero
      REG_DATA:   rdata_nxt = (!stat.dir && !stat.empty) ? stat.head : '0;
      default:    rdata_nxt = '0; // ACR and holes
    endcase
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) wb_ack <= 1'b0;
    else         wb_ack <= accept; // One cycle after the accept edge
  end

  // Sampled before the buffer moves, so a pop returns the old head
  always_ff @(posedge CLK) begin
    if (accept) wb_dat_r <= rdata_nxt;
  end

endmodule

`default_nettype wire

//--- logic/sdma_fifo_top.sv
// SCSI DMA data FIFO top; single clock domain, three registers only, wb_sel is ignored
`timescale 1ns/1ns
`default_nettype none

module sdma_fifo_top
  import sdma_fifo_pkg::*;
(
  input  wire        CLK,
  input  wire        arst_n,
  // Wishbone classic slave
  input  wire        wb_cyc,
  input  wire        wb_stb,
  input  wire        wb_we,
  input  reg_addr_t  wb_adr,
  input  word_t      wb_dat_w,
  input  wire  [3:0] wb_sel,
  output word_t      wb_dat_r,
  output logic       wb_ack,
  // SCSI byte in
  input  wire        byte_in_valid,
  input  byte_t      byte_in_data,
  output logic       byte_in_ready,
  // SCSI byte out
  output logic       byte_out_valid,
  output byte_t      byte_out_data,
  input  wire        byte_out_ready
);

  fifo_cmd_t  cmd;     // Decode to buffer
  fifo_stat_t stat;    // Buffer to response
  logic       accept;
  reg_addr_t  acc_adr;

  fifo_reg_decode decode_i (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .cmd      (cmd),
    .accept   (accept),
    .acc_adr  (acc_adr)
  );

  fifo_byte_lane_buffer buffer_i (
    .CLK            (CLK),
    .arst_n         (arst_n),
    .cmd            (cmd),
    .stat           (stat),
    .byte_in_valid  (byte_in_valid),
    .byte_in_data   (byte_in_data),
    .byte_in_ready  (byte_in_ready),
    .byte_out_valid (byte_out_valid),
    .byte_out_data  (byte_out_data),
    .byte_out_ready (byte_out_ready)
  );

  fifo_bus_response response_i (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .accept   (accept),
    .acc_adr  (acc_adr),
    .stat     (stat),
    .wb_ack   (wb_ack),
    .wb_dat_r (wb_dat_r)
  );

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
// Testbench clock and reset with an 8 ns period and reset released on a falling edge after two cycles
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic CLK,
  output logic arst_n
);

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK; // 8 ns period
  end

  initial begin
    arst_n = 1'b0;
    repeat (2) @(posedge CLK); // Two cycles in reset
    @(negedge CLK);
    arst_n = 1'b1; // Released away from the rising edge
  end

endmodule

`default_nettype wire

//--- tests/sdma_fifo_assert.sv
// Protocol checks bound into the FIFO top; they watch only the ack, the byte ports and STATUS reads
`timescale 1ns/1ns
`default_nettype none

module sdma_fifo_assert
  import sdma_fifo_pkg::*;
(
  input wire       CLK,
  input wire       arst_n,
  input wire       wb_ack,
  input wire       byte_in_ready,
  input wire       byte_out_valid,
  input wire       accept,
  input reg_addr_t acc_adr,
  input word_t     wb_dat_r
);

  // One ack cycle per request
  ack_one_cycle: assert property (@(posedge CLK) disable iff (!arst_n) wb_ack |=> !wb_ack)
    else $error("wb_ack stayed high for two cycles");

  // Only the port of the current direction is open
  ports_exclusive: assert property (@(posedge CLK) disable iff (!arst_n)
    !(byte_in_ready && byte_out_valid))
    else $error("byte_in_ready and byte_out_valid high together");

  level_in_range: assert property (@(posedge CLK) disable iff (!arst_n)
    (accept && (acc_adr == REG_STATUS)) |=> (wb_dat_r[STAT_LVL_LO +: 4] <= 4'd8))
    else $error("STATUS level above eight words");

endmodule

`default_nettype wire

//--- tests/sdma_fifo_tb.sv
// Directed testbench for the SCSI DMA FIFO; inputs change on the falling edge and only whole words are used
`timescale 1ns/1ns
`default_nettype none

module sdma_fifo_tb
  import sdma_fifo_pkg::*;
();

  localparam int N_XFERS = 114;              // Bus and byte transfers of all tests
  localparam int WDOG_NS = 20 * N_XFERS * 8;

  logic       CLK;
  logic       arst_n;
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_we;
  logic       wb_ack;
  logic [3:0] wb_sel;
  reg_addr_t  wb_adr;
  word_t      wb_dat_w;
  word_t      wb_dat_r;
  word_t      rd;                            // Last read data
  logic       byte_in_valid;
  logic       byte_in_ready;
  logic       byte_out_valid;
  logic       byte_out_ready;
  byte_t      byte_in_data;
  byte_t      byte_out_data;
  word_t      lcg_state = 32'd80691;
  int         n_errors = 0;
  int         n_checks = 0;

  tb_clock_gen clock_gen_i (.CLK(CLK), .arst_n(arst_n));

  sdma_fifo_top sdma_fifo_top_i (.*);

  bind sdma_fifo_top sdma_fifo_assert assert_i (
    .CLK(CLK), .arst_n(arst_n), .wb_ack(wb_ack),
    .byte_in_ready(byte_in_ready), .byte_out_valid(byte_out_valid),
    .accept(accept), .acc_adr(acc_adr), .wb_dat_r(wb_dat_r)
  );

  function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223; // Numerical Recipes constants
    return lcg_state;
  endfunction

  // STATUS word built from the register map
  function automatic word_t status_of(logic emp, logic ful, level_t lvl, byte_ofs_t ptr,
                                      logic ovf, logic unf, logic dir);
    return {21'd0, dir, unf, ovf, ptr, lvl, ful, emp};
  endfunction

  task automatic compare_value(input string name, input word_t exp, input word_t act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("[FAIL] %s: expected 0x%h, actual 0x%h", name, exp, act);
    end
  endtask

  task automatic report_stall(input string what);
    n_errors++;
    $display("Waited too long for %s", what);
  endtask

  // Classic cycle held until ack and then dropped
  task automatic bus_access(input logic we, input reg_addr_t adr, input word_t wdata,
                            output word_t rdata);
    int waited;
    waited = 0;
    @(negedge CLK);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    @(negedge CLK);
    compare_value("wb_ack", 32'd1, word_t'(wb_ack)); // Exactly one wait state
    while (!wb_ack && waited < 16) begin
      @(negedge CLK);
      waited++;
    end
    if (!wb_ack) report_stall("wb_ack");
    rdata  = wb_dat_r; // Stable mid-cycle
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic send_byte(input byte_t b);
    int waited;
    waited = 0;
    @(negedge CLK);
    byte_in_valid = 1'b1;
    byte_in_data  = b;
    while (!byte_in_ready && waited < 16) begin
      @(negedge CLK);
      waited++;
    end
    if (!byte_in_ready) report_stall("byte_in_ready");
    @(negedge CLK); // Moved at the rising edge before
    byte_in_valid = 1'b0;
  endtask

  task automatic take_byte(output byte_t b);
    int waited;
    waited = 0;
    @(negedge CLK);
    byte_out_ready = 1'b1;
    while (!byte_out_valid && waited < 16) begin
      @(negedge CLK);
      waited++;
    end
    if (!byte_out_valid) report_stall("byte_out_valid");
    b = byte_out_data;
    @(negedge CLK);
    byte_out_ready = 1'b0;
  endtask

  task automatic after_reset();
    @(negedge CLK);
    compare_value("wb_ack", 32'd0, word_t'(wb_ack));
    compare_value("byte_out_valid", 32'd0, word_t'(byte_out_valid));
    compare_value("byte_in_ready", 32'd1, word_t'(byte_in_ready));
    bus_access(1'b0, REG_STATUS, '0, rd);
    compare_value("status", status_of(1'b1, 1'b0, 4'd0, 2'd0, 1'b0, 1'b0, 1'b0), rd);
  endtask

  task automatic scsi_to_host();
    byte_t q [$];
    byte_t b;
    word_t exp;
    for (int i = 0; i < 32; i++) begin
      b = byte_t'(lcg_next() >> 24);
      q.push_back(b);
      send_byte(b);
    end
    compare_value("byte_in_ready", 32'd0, word_t'(byte_in_ready)); // Full
    bus_access(1'b0, REG_STATUS, '0, rd);
    compare_value("status", status_of(1'b0, 1'b1, 4'd8, 2'd0, 1'b0, 1'b0, 1'b0), rd);
    for (int w = 0; w < 8; w++) begin
      exp = {q[4*w], q[4*w+1], q[4*w+2], q[4*w+3]}; // Big-endian packing
      bus_access(1'b0, REG_DATA, '0, rd);
      compare_value("wb_dat_r", exp, rd);
    end
    bus_access(1'b0, REG_STATUS, '0, rd);
    compare_value("status", status_of(1'b1, 1'b0, 4'd0, 2'd0, 1'b0, 1'b0, 1'b0), rd);
    bus_access(1'b0, REG_DATA, '0, rd); // Pop while empty
    compare_value("wb_dat_r", 32'd0, rd);
    bus_access(1'b0, REG_STATUS, '0, rd);
    compare_value("status", status_of(1'b1, 1'b0, 4'd0, 2'd0, 1'b0, 1'b1, 1'b0), rd);
  endtask

  task automatic host_to_scsi();
    word_t w [$];
    word_t exp_w;
    byte_t b;
    bus_access(1'b1, REG_ACR, 32'h3, rd); // Direction 1 with FIFO reset
    for (int i = 0; i < 8; i++) begin
      w.push_back(lcg_next());
      bus_access(1'b1, REG_DATA, w[i], rd);
    end
    bus_access(1'b0, REG_STATUS, '0, rd);
    compare_value("status", status_of(1'b0, 1'b1, 4'd8, 2'd0, 1'b0, 1'b0, 1'b1), rd);
    bus_access(1'b1, REG_DATA, lcg_next(), rd); // Ninth word is dropped
    bus_access(1'b0, REG_STATUS, '0, rd);
    compare_value("status", status_of(1'b0, 1'b1, 4'd8, 2'd0, 1'b1, 1'b0, 1'b1), rd);
    for (int i = 0; i < 32; i++) begin
      take_byte(b);
      exp_w = w[i/4];
      compare_value("byte_out_data", {24'd0, exp_w[8*(3-i%4) +: 8]}, {24'd0, b});
    end
    compare_value("byte_out_valid", 32'd0, word_t'(byte_out_valid));
  endtask

  task automatic start_offset();
    byte_t b0;
    byte_t b1;
    bus_access(1'b1, REG_ACR, 32'hA, rd); // Reset, offset 2, direction 0
    b0 = byte_t'(lcg_next() >> 24);
    b1 = byte_t'(lcg_next() >> 24);
    send_byte(b0);
    send_byte(b1);
    bus_access(1'b0, REG_STATUS, '0, rd);
    compare_value("status", status_of(1'b0, 1'b0, 4'd1, 2'd0, 1'b0, 1'b0, 1'b0), rd);
    bus_access(1'b0, REG_DATA, '0, rd);
    compare_value("wb_dat_r[15:0]", {16'd0, b0, b1}, {16'd0, rd[15:0]}); // Upper lanes stale
  endtask

  task automatic acr_reset();
    bus_access(1'b0, REG_DATA, '0, rd); // Raises underflow
    compare_value("wb_dat_r", 32'd0, rd);
    for (int i = 0; i < 5; i++) send_byte(byte_t'(lcg_next() >> 24));
    bus_access(1'b0, REG_STATUS, '0, rd);
    compare_value("status", status_of(1'b0, 1'b0, 4'd1, 2'd1, 1'b0, 1'b1, 1'b0), rd);
    bus_access(1'b1, REG_ACR, 32'h6, rd); // Reset with offset 1
    bus_access(1'b0, REG_STATUS, '0, rd);
    compare_value("status", status_of(1'b1, 1'b0, 4'd0, 2'd1, 1'b0, 1'b0, 1'b0), rd);
  endtask

  task automatic wrong_direction();
    bus_access(1'b1, REG_ACR, 32'h2, rd);
    for (int i = 0; i < 4; i++) send_byte(byte_t'(lcg_next() >> 24));
    bus_access(1'b1, REG_DATA, lcg_next(), rd); // Write in direction 0
    bus_access(1'b0, REG_STATUS, '0, rd);
    compare_value("status", status_of(1'b0, 1'b0, 4'd1, 2'd0, 1'b0, 1'b0, 1'b0), rd);
    bus_access(1'b1, REG_ACR, 32'h3, rd);
    bus_access(1'b1, REG_DATA, lcg_next(), rd);
    bus_access(1'b0, REG_DATA, '0, rd); // Read in direction 1
    compare_value("wb_dat_r", 32'd0, rd);
    bus_access(1'b0, REG_STATUS, '0, rd);
    compare_value("status", status_of(1'b0, 1'b0, 4'd1, 2'd0, 1'b0, 1'b0, 1'b1), rd);
  endtask

  initial begin
    wb_cyc         = 1'b0;
    wb_stb         = 1'b0;
    wb_we          = 1'b0;
    wb_sel         = 4'hF;
    wb_adr         = '0;
    wb_dat_w       = '0;
    byte_in_valid  = 1'b0;
    byte_in_data   = '0;
    byte_out_ready = 1'b0;
    wait (arst_n === 1'b1);
    after_reset();
    scsi_to_host();
    host_to_scsi();
    start_offset();
    acr_reset();
    wrong_direction();
    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog sized from the transfer count
  initial begin
    #(WDOG_NS);
    $display("Simulation stuck after %0d ns, watchdog ended the run", WDOG_NS);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
logic/sdma_fifo_pkg.sv
logic/fifo_reg_decode.sv
logic/fifo_byte_lane_buffer.sv
logic/fifo_bus_response.sv
logic/sdma_fifo_top.sv
tests/tb_clock_gen.sv
tests/sdma_fifo_assert.sv
tests/sdma_fifo_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the FIFO testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module sdma_fifo_tb -f build.f -o sdma_fifo_sim
./obj_dir/sdma_fifo_sim | tee sim.log
if grep -q "^Result: PASSED$" sim.log; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1
